/* hdl/nes_cpu_pkg.sv */
// nes cpu glue package
// bus addresses, widths, dma state and the bus structs shared by the 2A03 glue

package nes_cpu_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [7:0]  dma_count_t;  // bytes still to move

    // who owns the system bus
    typedef enum logic [1:0]
    {
        DMA_IDLE  = 2'd0,   // core owns the bus
        DMA_START = 2'd1,   // dummy cycle
        DMA_READ  = 2'd2,
        DMA_WRITE = 2'd3
    } dma_state_e;

    // what the 6502 core drives
    typedef struct packed
    {
        addr_t address;
        data_t wdata;
        logic  rw;
        logic  sync;
    } cpu_bus_t;

    // what the chip drives onto the system bus
    typedef struct packed
    {
        addr_t address;
        data_t wdata;
        logic  rw;
        logic  sync;
    } sys_bus_t;

    localparam addr_t ADDRESS_OAMDMA  = 16'h4014;
    localparam addr_t ADDRESS_OAMDATA = 16'h2004;
    localparam addr_t ADDRESS_JOY1    = 16'h4016;

    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    localparam dma_count_t OAM_DMA_LAST = 8'd255;  // 256 transfers

endpackage

/* hdl/oam_dma_fsm.sv */
// OAM DMA state machine
// detects the 4014h write, walks start/read/write and holds the byte read

`timescale 1ns/100ps

module oam_dma_fsm
(
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_clk_en,
    input  nes_cpu_pkg::cpu_bus_t  i_cpu_bus,
    input  nes_cpu_pkg::data_t     i_data,
    input  logic                   i_last,
    output nes_cpu_pkg::dma_state_e o_state,
    output logic                   o_load,
    output logic                   o_step,
    output nes_cpu_pkg::data_t     o_dma_data
);

    nes_cpu_pkg::dma_state_e r_state;
    nes_cpu_pkg::dma_state_e w_next_state;
    nes_cpu_pkg::data_t      r_dma_data;
    logic                    w_trigger;

    // core write to the dma register while it still owns the bus
    assign w_trigger = (r_state == nes_cpu_pkg::DMA_IDLE) &&
                       (i_cpu_bus.address == nes_cpu_pkg::ADDRESS_OAMDMA) &&
                       (i_cpu_bus.rw == nes_cpu_pkg::RW_WRITE);

    assign o_load = i_clk_en && w_trigger;
    assign o_step = i_clk_en && (r_state == nes_cpu_pkg::DMA_WRITE);

    always_comb
    begin
        w_next_state = r_state;
        case (r_state)
            nes_cpu_pkg::DMA_IDLE:
            begin
                if (w_trigger)
                begin
                    w_next_state = nes_cpu_pkg::DMA_START;
                end
            end
            nes_cpu_pkg::DMA_START:
                w_next_state = nes_cpu_pkg::DMA_READ;
            nes_cpu_pkg::DMA_READ:
                w_next_state = nes_cpu_pkg::DMA_WRITE;
            nes_cpu_pkg::DMA_WRITE:
            begin
                if (i_last)
                begin
                    w_next_state = nes_cpu_pkg::DMA_IDLE;  // 256th byte written
                end
                else
                begin
                    w_next_state = nes_cpu_pkg::DMA_READ;
                end
            end
            default:
                w_next_state = nes_cpu_pkg::DMA_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_state <= nes_cpu_pkg::DMA_IDLE;
        end
        else if (i_clk_en)
        begin
            r_state <= w_next_state;
        end
    end

    // byte from the source page, written out on the next cycle
    always_ff @(posedge i_clk)
    begin
        if (i_clk_en && (r_state == nes_cpu_pkg::DMA_READ))
        begin
            r_dma_data <= i_data;
        end
    end

    assign o_state    = r_state;
    assign o_dma_data = r_dma_data;

endmodule

/* hdl/oam_dma_counter.sv */
// OAM DMA address and byte counter
// source address within the page and the count of bytes left

`timescale 1ns/100ps

module oam_dma_counter
(
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic               i_clk_en,
    input  logic               i_load,
    input  nes_cpu_pkg::data_t i_page,
    input  logic               i_step,
    output nes_cpu_pkg::addr_t o_address,
    output logic               o_last
);

    nes_cpu_pkg::addr_t      r_address;
    nes_cpu_pkg::dma_count_t r_count;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_count <= '0;
        end
        else if (i_clk_en)
        begin
            if (i_load)
            begin
                r_count <= nes_cpu_pkg::OAM_DMA_LAST;
            end
            else if (i_step)
            begin
                r_count <= r_count - 8'd1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_clk_en)
        begin
            if (i_load)
            begin
                r_address <= {i_page, 8'h00};  // start of page P
            end
            else if (i_step)
            begin
                r_address <= r_address + 16'd1;
            end
        end
    end

    assign o_address = r_address;
    assign o_last    = (r_count == '0);  // final pair in progress

endmodule

/* hdl/cpu_bus_mux.sv */
// system bus mux
// picks core or dma as the bus driver and gates the core clock enable

`timescale 1ns/100ps

module cpu_bus_mux
(
    input  logic                    i_clk_en,
    input  nes_cpu_pkg::dma_state_e i_state,
    input  nes_cpu_pkg::cpu_bus_t   i_cpu_bus,
    input  nes_cpu_pkg::addr_t      i_dma_address,
    input  nes_cpu_pkg::data_t      i_dma_data,
    output nes_cpu_pkg::sys_bus_t   o_bus,
    output logic                    o_cpu_clk_en
);

    always_comb
    begin
        case (i_state)
            nes_cpu_pkg::DMA_START:
            begin
                o_bus.address = '0;  // dummy read
                o_bus.wdata   = '0;
                o_bus.rw      = nes_cpu_pkg::RW_READ;
                o_bus.sync    = 1'b0;
            end
            nes_cpu_pkg::DMA_READ:
            begin
                o_bus.address = i_dma_address;
                o_bus.wdata   = '0;
                o_bus.rw      = nes_cpu_pkg::RW_READ;
                o_bus.sync    = 1'b0;
            end
            nes_cpu_pkg::DMA_WRITE:
            begin
                o_bus.address = nes_cpu_pkg::ADDRESS_OAMDATA;
                o_bus.wdata   = i_dma_data;
                o_bus.rw      = nes_cpu_pkg::RW_WRITE;
                o_bus.sync    = 1'b0;
            end
            default:
            begin
                o_bus.address = i_cpu_bus.address;
                o_bus.wdata   = i_cpu_bus.wdata;
                o_bus.rw      = i_cpu_bus.rw;
                o_bus.sync    = i_cpu_bus.sync;
            end
        endcase
    end

    // core stalls for the whole transfer
    assign o_cpu_clk_en = (i_state == nes_cpu_pkg::DMA_IDLE) ? i_clk_en : 1'b0;

endmodule

/* hdl/joypad_port.sv */
// controller port
// strobe latch and controller 1 read enable at 4016h

`timescale 1ns/100ps

module joypad_port
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_cpu_clk_en,
    input  nes_cpu_pkg::cpu_bus_t i_cpu_bus,
    output logic                  o_out0,
    output logic                  o_oe1_n
);

    logic w_joy1_hit;
    logic r_out0;

    assign w_joy1_hit = (i_cpu_bus.address == nes_cpu_pkg::ADDRESS_JOY1);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_out0 <= 1'b0;
        end
        else if (i_cpu_clk_en && w_joy1_hit && (i_cpu_bus.rw == nes_cpu_pkg::RW_WRITE))
        begin
            r_out0 <= i_cpu_bus.wdata[0];  // strobe for both pads
        end
    end

    assign o_out0 = r_out0;

    // active low, same cycle as the read
    assign o_oe1_n = !(i_cpu_clk_en && w_joy1_hit &&
                       (i_cpu_bus.rw == nes_cpu_pkg::RW_READ));

endmodule

/* hdl/nes_cpu_bus.sv */
// 2A03 bus glue top level
// OAM DMA engine, system bus ownership and the controller port

`timescale 1ns/100ps

module nes_cpu_bus
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_clk_en,      // from the clock divider
    input  nes_cpu_pkg::cpu_bus_t i_cpu_bus,
    input  nes_cpu_pkg::data_t    i_data,
    output logic                  o_cpu_clk_en,  // to the 6502 core
    output nes_cpu_pkg::sys_bus_t o_bus,
    output logic                  o_out0,
    output logic                  o_oe1_n
);

    nes_cpu_pkg::dma_state_e w_dma_state;
    logic                    w_dma_load;
    logic                    w_dma_step;
    nes_cpu_pkg::data_t      w_dma_data;
    nes_cpu_pkg::addr_t      w_dma_address;
    logic                    w_dma_last;

    oam_dma_fsm u_oam_dma_fsm
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_clk_en   (i_clk_en),
        .i_cpu_bus  (i_cpu_bus),
        .i_data     (i_data),
        .i_last     (w_dma_last),
        .o_state    (w_dma_state),
        .o_load     (w_dma_load),
        .o_step     (w_dma_step),
        .o_dma_data (w_dma_data)
    );

    oam_dma_counter u_oam_dma_counter
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clk_en  (i_clk_en),
        .i_load    (w_dma_load),
        .i_page    (i_cpu_bus.wdata),  // page number written to 4014h
        .i_step    (w_dma_step),
        .o_address (w_dma_address),
        .o_last    (w_dma_last)
    );

    cpu_bus_mux u_cpu_bus_mux
    (
        .i_clk_en      (i_clk_en),
        .i_state       (w_dma_state),
        .i_cpu_bus     (i_cpu_bus),
        .i_dma_address (w_dma_address),
        .i_dma_data    (w_dma_data),
        .o_bus         (o_bus),
        .o_cpu_clk_en  (o_cpu_clk_en)
    );

    // gated enable keeps dma cycles away from the pads
    joypad_port u_joypad_port
    (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_cpu_clk_en (o_cpu_clk_en),
        .i_cpu_bus    (i_cpu_bus),
        .o_out0       (o_out0),
        .o_oe1_n      (o_oe1_n)
    );

endmodule

/* verification/tb_clock_gen.sv */
// testbench clock and reset
// 10 ns clock, reset held low for the first 3 cycles

`timescale 1ns/100ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #5 o_clk = ~o_clk;
        end
    end

    initial
    begin
        o_reset_n = 1'b0;
        repeat (3) @(posedge o_clk);
        #1 o_reset_n = 1'b1;  // released off the edge like the other inputs
    end

endmodule

/* verification/tb_nes_cpu_bus.sv */
// testbench for the 2A03 bus glue
// directed tests for pass-through, controller port and OAM DMA with a memory model

`timescale 1ns/100ps

module tb_nes_cpu_bus;

    localparam int WATCHDOG_CYCLES = 2 * 513 * 4 + 2000;

    logic                  clk;
    logic                  reset_n;
    logic                  clk_en;
    nes_cpu_pkg::cpu_bus_t cpu_bus;
    nes_cpu_pkg::data_t    rdata;
    logic                  cpu_clk_en;
    nes_cpu_pkg::sys_bus_t sys_bus;
    logic                  out0;
    logic                  oe1_n;

    nes_cpu_pkg::data_t mem [0:65535];
    int error_count;
    int pass_count;
    int fail_count;

    tb_clock_gen u_clock_gen
    (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    nes_cpu_bus DUT
    (
        .i_clk        (clk),
        .i_reset_n    (reset_n),
        .i_clk_en     (clk_en),
        .i_cpu_bus    (cpu_bus),
        .i_data       (rdata),
        .o_cpu_clk_en (cpu_clk_en),
        .o_bus        (sys_bus),
        .o_out0       (out0),
        .o_oe1_n      (oe1_n)
    );

    assign rdata = mem[sys_bus.address];  // memory answers in the same cycle

    function automatic nes_cpu_pkg::cpu_bus_t bus_word(input logic [15:0] address,
        input logic [7:0] wdata, input logic rw, input logic sync);
        nes_cpu_pkg::cpu_bus_t b;
        b.address = address;
        b.wdata   = wdata;
        b.rw      = rw;
        b.sync    = sync;
        return b;
    endfunction

    // n = 1 is the dummy cycle, then read/write pairs for byte k
    function automatic nes_cpu_pkg::sys_bus_t dma_bus_at(input int n, input logic [7:0] page);
        nes_cpu_pkg::sys_bus_t b;
        int k;
        k = (n - 2) / 2;
        b.sync = 1'b0;
        if (n == 1)
        begin
            b.address = 16'h0000;
            b.wdata   = 8'h00;
            b.rw      = 1'b1;
        end
        else if (n % 2 == 0)
        begin
            b.address = {page, k[7:0]};
            b.wdata   = 8'h00;
            b.rw      = 1'b1;
        end
        else
        begin
            b.address = 16'h2004;  // OAM data port
            b.wdata   = mem[{page, k[7:0]}];
            b.rw      = 1'b0;
        end
        return b;
    endfunction

    // inputs 1 ns after the edge, returns just before the next edge
    task automatic drive_cycle(input nes_cpu_pkg::cpu_bus_t b, input logic en);
        @(posedge clk);
        #1;
        cpu_bus = b;
        clk_en  = en;
        #8;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("mismatch %s expected %0h actual %0h at %0t", name, expected, actual,
                $time);
            error_count++;
        end
    endtask

    task automatic compare_bus(input nes_cpu_pkg::sys_bus_t expected);
        check_value("o_bus.address", expected.address, sys_bus.address);
        check_value("o_bus.wdata", expected.wdata, sys_bus.wdata);
        check_value("o_bus.rw", expected.rw, sys_bus.rw);
        check_value("o_bus.sync", expected.sync, sys_bus.sync);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before)
        begin
            pass_count++;
            $display("%s: ok", name);
        end
        else
        begin
            fail_count++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic reset_defaults();
        int errors_before;
        nes_cpu_pkg::cpu_bus_t core;
        errors_before = error_count;
        core = bus_word(16'hfffc, 8'h00, 1'b1, 1'b0);
        drive_cycle(core, 1'b1);
        check_value("o_out0", 1'b0, out0);
        check_value("o_oe1_n", 1'b1, oe1_n);
        check_value("o_cpu_clk_en", 1'b1, cpu_clk_en);
        compare_bus(core);
        drive_cycle(core, 1'b0);
        check_value("o_cpu_clk_en", 1'b0, cpu_clk_en);
        compare_bus(core);
        finish_test("reset state", errors_before);
    endtask

    task automatic pass_through();
        int errors_before;
        nes_cpu_pkg::cpu_bus_t core;
        logic [15:0] address;
        logic en;
        errors_before = error_count;
        for (int i = 0; i < 50; i++)
        begin
            do
            begin
                address = $urandom;
            end
            while (address == 16'h4014 || address == 16'h4016);
            core = bus_word(address, $urandom, $urandom, $urandom);
            en = $urandom;
            drive_cycle(core, en);
            compare_bus(core);
            check_value("o_cpu_clk_en", en, cpu_clk_en);
        end
        finish_test("pass-through", errors_before);
    endtask

    task automatic controller_port();
        int errors_before;
        logic b;
        errors_before = error_count;
        for (int i = 0; i < 2; i++)
        begin
            b = (i == 0);
            drive_cycle(bus_word(16'h4016, {7'h55, b}, 1'b0, 1'b0), 1'b1);
            drive_cycle(bus_word(16'h0200, {7'h00, ~b}, 1'b0, 1'b0), 1'b1);
            check_value("o_out0", b, out0);
            drive_cycle(bus_word(16'h4017, {7'h7f, ~b}, 1'b0, 1'b0), 1'b1);
            check_value("o_out0", b, out0);
            drive_cycle(bus_word(16'h0200, 8'h00, 1'b1, 1'b0), 1'b1);
            check_value("o_out0", b, out0);  // other writes leave the strobe
        end
        drive_cycle(bus_word(16'h4016, 8'h00, 1'b1, 1'b0), 1'b1);
        check_value("o_oe1_n", 1'b0, oe1_n);
        drive_cycle(bus_word(16'h4015, 8'h00, 1'b1, 1'b0), 1'b1);
        check_value("o_oe1_n", 1'b1, oe1_n);
        finish_test("controller port", errors_before);
    endtask

    task automatic oam_dma_transfer(input string name, input logic stalls);
        int errors_before;
        int n;
        logic [7:0] page;
        logic strobe;
        logic en;
        nes_cpu_pkg::cpu_bus_t core;
        errors_before = error_count;
        page = $urandom;
        strobe = out0;
        drive_cycle(bus_word(16'h4014, page, 1'b0, 1'b0), 1'b1);  // trigger
        n = 1;
        while (n <= 514)
        begin
            en = 1'b1;
            if (stalls && ($urandom % 4 == 0))
            begin
                en = 1'b0;
            end
            if (n <= 513)
            begin
                core = bus_word(16'h4016, {7'h00, ~strobe}, 1'b0, 1'b1);  // must not land
            end
            else
            begin
                core = bus_word(16'h0100, 8'h00, 1'b1, 1'b0);
            end
            drive_cycle(core, en);
            if (n <= 513)
            begin
                compare_bus(dma_bus_at(n, page));
                check_value("o_cpu_clk_en", 1'b0, cpu_clk_en);
            end
            else
            begin
                compare_bus(core);
                check_value("o_cpu_clk_en", en, cpu_clk_en);
            end
            check_value("o_out0", strobe, out0);
            if (en)
            begin
                n++;
            end
        end
        finish_test(name, errors_before);
    endtask

    task automatic no_false_trigger();
        int errors_before;
        nes_cpu_pkg::cpu_bus_t core;
        errors_before = error_count;
        core = bus_word(16'h4014, 8'h02, 1'b1, 1'b0);
        drive_cycle(core, 1'b1);
        compare_bus(core);
        for (int i = 0; i < 4; i++)
        begin
            core = bus_word(16'h0300 + i, 8'h00, 1'b1, 1'b0);
            drive_cycle(core, i[0]);
            compare_bus(core);
            check_value("o_cpu_clk_en", i[0], cpu_clk_en);
        end
        finish_test("no false trigger", errors_before);
    endtask

    initial
    begin
        int seed_value;
        cpu_bus     = bus_word(16'h0000, 8'h00, 1'b1, 1'b0);
        clk_en      = 1'b1;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        seed_value  = $urandom(32'h17e0);
        for (int a = 0; a < 65536; a++)
        begin
            mem[a] = $urandom;
        end
        @(posedge reset_n);
        reset_defaults();
        pass_through();
        controller_port();
        oam_dma_transfer("oam dma", 1'b0);
        oam_dma_transfer("oam dma with stalls", 1'b1);
        no_false_trigger();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // long enough for both transfers even with heavy stalling
    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* all.f */
hdl/nes_cpu_pkg.sv
hdl/oam_dma_fsm.sv
hdl/oam_dma_counter.sv
hdl/cpu_bus_mux.sv
hdl/joypad_port.sv
hdl/nes_cpu_bus.sv
verification/tb_clock_gen.sv
verification/tb_nes_cpu_bus.sv
